// File: sim.f
hw/vmem_pkg.sv
hw/axi_cfg_pkg.sv
hw/burst_boundary.sv
hw/lsu_credit_tracker.sv
hw/mem_op_frontend.sv
hw/axi_req_gen.sv
hw/addrgen_top.sv
test/addrgen_asserts.sv
test/addrgen_tb.sv

// File: test/addrgen_tb.sv
//////////////////////////////////////////////////
// Testbench for the vector address generator
// Drives requests, models the expected AXI and
// LSU command stream and checks every transfer
//////////////////////////////////////////////////

`timescale 1ns/10ps

module addrgen_tb;

  import vmem_pkg::*;
  import axi_cfg_pkg::*;

  localparam int NumRequests    = 9;
  localparam int WatchdogCycles = 200 * NumRequests + 1000;
  // Clock edges from request to error ack
  localparam int MisalignEdges  = 3;

  logic       clk_i = 1'b0;
  logic       rst_ni;
  logic       req_valid_i;
  vaddr_t     req_addr_i;
  vlen_t      req_len_i;
  stride_t    req_stride_i;
  vew_e       req_vew_i;
  logic       req_is_load_i;
  logic       req_unit_stride_i;
  logic       ack_o;
  logic       error_o;
  logic       ar_valid_o;
  logic       ar_ready_i;
  vaddr_t     ar_addr_o;
  axi_len_t   ar_len_o;
  axi_size_t  ar_size_o;
  axi_burst_t ar_burst_o;
  logic       aw_valid_o;
  logic       aw_ready_i;
  vaddr_t     aw_addr_o;
  axi_len_t   aw_len_o;
  axi_size_t  aw_size_o;
  axi_burst_t aw_burst_o;
  logic       cmd_valid_o;
  vaddr_t     cmd_addr_o;
  axi_len_t   cmd_len_o;
  axi_size_t  cmd_size_o;
  logic       cmd_is_load_o;
  logic       credit_i;

  // Expected transfers, in order
  vaddr_t     exp_addr[$];
  axi_len_t   exp_len[$];
  axi_size_t  exp_size[$];
  logic       exp_load[$];

  string      test_name;
  int         seed;
  int         error_cnt;
  int         outstanding;
  int         aw_cnt;
  int         aw_before;
  logic       last_dir;
  logic       hold_credits;
  logic       ar_fire;
  logic       aw_fire;

  addrgen_top dut0 (.*);

  always #5 clk_i = ~clk_i;

  task automatic check_field(input string field, input logic [31:0] exp,
                             input logic [31:0] act);
    assert (exp == act) else begin
      $display("ERROR %s: %s expected 0x%0h actual 0x%0h", test_name, field, exp, act);
      error_cnt++;
    end
  endtask

  task automatic expect_xfer(input vaddr_t addr, input axi_len_t len, input axi_size_t size,
                             input logic is_load);
    exp_addr.push_back(addr);
    exp_len.push_back(len);
    exp_size.push_back(size);
    exp_load.push_back(is_load);
  endtask

  //////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////

  task automatic model_request(input vaddr_t base, input vlen_t len, input stride_t stride,
                               input vew_e vew, input logic is_load, input logic unit);
    vaddr_t      addr;
    vaddr_t      first;
    vaddr_t      last_byte;
    vaddr_t      page_last;
    vaddr_t      covered;
    logic [31:0] rem;
    int          i;
    // Misaligned base gives no traffic
    if ((base & ((32'd1 << vew) - 32'd1)) != 0) begin
      return;
    end
    if (unit) begin
      addr = base;
      rem  = 32'(len) << vew;
      while (rem != 0) begin
        first     = addr & ~vaddr_t'(AxiDataBytes - 1);
        last_byte = (addr + rem - 1) | vaddr_t'(AxiDataBytes - 1);
        if (first + MaxBurstBeats * AxiDataBytes - 1 < last_byte) begin
          last_byte = first + MaxBurstBeats * AxiDataBytes - 1;
        end
        page_last = addr | ((32'd1 << PageOffsetBits) - 32'd1);
        if (page_last < last_byte) begin
          last_byte = page_last;
        end
        expect_xfer(addr, axi_len_t'((last_byte - first) / AxiDataBytes),
                    axi_size_t'(AxiSizeLog), is_load);
        covered = last_byte + 1 - addr;
        rem     = (covered >= rem) ? 32'd0 : rem - covered;
        addr    = last_byte + 1;
      end
    end else begin
      for (i = 0; i < int'(len); i++) begin
        expect_xfer(base + vaddr_t'(i) * stride, (vew == EW64) ? 8'd1 : 8'd0,
                    (int'(vew) < AxiSizeLog) ? axi_size_t'(vew) : axi_size_t'(AxiSizeLog),
                    is_load);
      end
    end
  endtask

  task automatic issue_request(input vaddr_t base, input vlen_t len, input stride_t stride,
                               input vew_e vew, input logic is_load, input logic unit);
    @(negedge clk_i);
    model_request(base, len, stride, vew, is_load, unit);
    req_addr_i        = base;
    req_len_i         = len;
    req_stride_i      = stride;
    req_vew_i         = vew;
    req_is_load_i     = is_load;
    req_unit_stride_i = unit;
    req_valid_i       = 1'b1;
  endtask

  // Zero for exp_edges skips the latency check
  task automatic wait_ack(input logic exp_error, input int exp_edges);
    int edges;
    edges = 0;
    do begin
      @(posedge clk_i);
      edges++;
    end while (!ack_o);
    check_field("error_o", exp_error, error_o);
    if (exp_edges != 0) begin
      check_field("ack latency", exp_edges, edges);
    end
    check_field("missing transfers", 0, exp_addr.size());
    @(negedge clk_i);
    req_valid_i = 1'b0;
  endtask

  task automatic check_transfer(input logic is_ar);
    assert (exp_addr.size() != 0) else begin
      $display("ERROR %s: AXI transfer at 0x%0h with nothing expected", test_name,
               is_ar ? ar_addr_o : aw_addr_o);
      error_cnt++;
    end
    if (exp_addr.size() != 0) begin
      check_field("is_load", exp_load[0], is_ar);
      check_field("address", exp_addr[0], is_ar ? ar_addr_o : aw_addr_o);
      check_field("len", exp_len[0], is_ar ? ar_len_o : aw_len_o);
      check_field("size", exp_size[0], is_ar ? ar_size_o : aw_size_o);
      check_field("burst", BurstIncr, is_ar ? ar_burst_o : aw_burst_o);
      check_field("cmd address", exp_addr[0], cmd_addr_o);
      check_field("cmd len", exp_len[0], cmd_len_o);
      check_field("cmd size", exp_size[0], cmd_size_o);
      check_field("cmd is_load", exp_load[0], cmd_is_load_o);
      void'(exp_addr.pop_front());
      void'(exp_len.pop_front());
      void'(exp_size.pop_front());
      void'(exp_load.pop_front());
    end
  endtask

  //////////////////////////////////////////////////
  // Monitor and responders
  //////////////////////////////////////////////////

  always @(posedge clk_i) begin
    if (rst_ni) begin
      ar_fire = ar_valid_o && ar_ready_i;
      aw_fire = aw_valid_o && aw_ready_i;
      if (ar_fire || aw_fire) begin
        check_transfer(ar_fire);
      end
      if (cmd_valid_o) begin
        if (outstanding != 0) begin
          check_field("direction with commands pending", last_dir, cmd_is_load_o);
        end
        last_dir = cmd_is_load_o;
        outstanding++;
      end
      if (credit_i) begin
        outstanding--;
      end
      if (aw_fire) begin
        aw_cnt++;
      end
    end
  end

  // Random ready and credit return, one seed for both
  always @(negedge clk_i) begin
    ar_ready_i = ($random(seed) & 3) != 0;
    aw_ready_i = ($random(seed) & 3) != 0;
    credit_i   = !hold_credits && (outstanding > 0) && (($random(seed) & 1) != 0);
  end

  initial begin
    repeat (WatchdogCycles) @(posedge clk_i);
    $display("Watchdog expired after %0d cycles with a request still open", WatchdogCycles);
    $display("Simulation failed");
    $finish;
  end

  //////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////

  initial begin
    seed              = 93460;
    error_cnt         = 0;
    outstanding       = 0;
    aw_cnt            = 0;
    last_dir          = 1'b0;
    hold_credits      = 1'b0;
    rst_ni            = 1'b0;
    req_valid_i       = 1'b0;
    req_addr_i        = '0;
    req_len_i         = '0;
    req_stride_i      = '0;
    req_vew_i         = EW8;
    req_is_load_i     = 1'b0;
    req_unit_stride_i = 1'b0;
    ar_ready_i        = 1'b0;
    aw_ready_i        = 1'b0;
    credit_i          = 1'b0;
    repeat (4) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;

    test_name = "misaligned";
    issue_request(32'h0000_1002, 16'd4, 32'd4, EW32, 1'b1, 1'b1);
    wait_ack(1'b1, MisalignEdges);

    test_name = "unit_load_in_page";
    issue_request(32'h0000_0103, 16'd10, 32'd1, EW8, 1'b1, 1'b1);
    wait_ack(1'b0, 0);

    test_name = "unit_store_page_cross";
    issue_request(32'h0000_1ff0, 16'd8, 32'd4, EW32, 1'b0, 1'b1);
    wait_ack(1'b0, 0);

    test_name = "unit_load_long";
    issue_request(32'h0000_3000, 16'd700, 32'd4, EW32, 1'b1, 1'b1);
    wait_ack(1'b0, 0);

    test_name = "strided_store_ew64";
    issue_request(32'h0000_2000, 16'd4, 32'd24, EW64, 1'b0, 1'b0);
    wait_ack(1'b0, 0);

    test_name = "strided_store_ew16";
    issue_request(32'h0000_2102, 16'd5, 32'd6, EW16, 1'b0, 1'b0);
    wait_ack(1'b0, 0);
    // Every store credit home before the loads start
    while (outstanding != 0) @(negedge clk_i);

    // Withheld credits cap the commands in flight
    test_name = "credit_limit";
    hold_credits <= 1'b1;
    issue_request(32'h0000_4000, 16'd6, 32'd8, EW32, 1'b1, 1'b0);
    repeat (40) @(negedge clk_i);
    check_field("commands in flight", CmdCredits, outstanding);
    hold_credits <= 1'b0;
    wait_ack(1'b0, 0);
    while (outstanding != 0) @(negedge clk_i);

    // Store waits for every load credit
    test_name = "direction_switch";
    hold_credits <= 1'b1;
    issue_request(32'h0000_4100, 16'd3, 32'd4, EW32, 1'b1, 1'b0);
    wait_ack(1'b0, 0);
    aw_before = aw_cnt;
    issue_request(32'h0000_4200, 16'd2, 32'd16, EW32, 1'b0, 1'b0);
    repeat (30) @(negedge clk_i);
    check_field("stores before load credits", 0, aw_cnt - aw_before);
    hold_credits <= 1'b0;
    wait_ack(1'b0, 0);

    repeat (5) @(negedge clk_i);
    $display("Check errors: %0d, assertion failures: %0d", error_cnt,
             dut0.u_asserts.fail_cnt);
    if (error_cnt == 0 && dut0.u_asserts.fail_cnt == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// File: test/addrgen_asserts.sv
//////////////////////////////////////////////////
// Protocol checks for the address generator
// AXI stall stability, command pairing, credit
// limit and acknowledge pulse width
//////////////////////////////////////////////////

`timescale 1ns/10ps

module addrgen_asserts (
  input logic                    clk_i,
  input logic                    rst_ni,
  input logic                    ack_o,
  input logic                    ar_valid_o,
  input logic                    ar_ready_i,
  input vmem_pkg::vaddr_t        ar_addr_o,
  input axi_cfg_pkg::axi_len_t   ar_len_o,
  input axi_cfg_pkg::axi_size_t  ar_size_o,
  input axi_cfg_pkg::axi_burst_t ar_burst_o,
  input logic                    aw_valid_o,
  input logic                    aw_ready_i,
  input vmem_pkg::vaddr_t        aw_addr_o,
  input axi_cfg_pkg::axi_len_t   aw_len_o,
  input axi_cfg_pkg::axi_size_t  aw_size_o,
  input axi_cfg_pkg::axi_burst_t aw_burst_o,
  input logic                    cmd_valid_o,
  input logic                    credit_i
);

  import vmem_pkg::*;

  // Failed assertions, read by the testbench at the end
  int fail_cnt = 0;
  int in_flight;

  // Commands pushed but not yet credited back
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      in_flight <= 0;
    end else begin
      in_flight <= in_flight + int'(cmd_valid_o) - int'(credit_i);
    end
  end

  ar_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    ar_valid_o && !ar_ready_i |=> ar_valid_o && $stable(ar_addr_o) && $stable(ar_len_o)
      && $stable(ar_size_o) && $stable(ar_burst_o))
    else begin
      $error("AR request changed or dropped while stalled");
      fail_cnt++;
    end

  aw_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    aw_valid_o && !aw_ready_i |=> aw_valid_o && $stable(aw_addr_o) && $stable(aw_len_o)
      && $stable(aw_size_o) && $stable(aw_burst_o))
    else begin
      $error("AW request changed or dropped while stalled");
      fail_cnt++;
    end

  cmd_with_xfer: assert property (@(posedge clk_i) disable iff (!rst_ni)
    cmd_valid_o == ((ar_valid_o && ar_ready_i) || (aw_valid_o && aw_ready_i)))
    else begin
      $error("LSU command without a matching AXI transfer");
      fail_cnt++;
    end

  credit_limit: assert property (@(posedge clk_i) disable iff (!rst_ni)
    in_flight <= int'(CmdCredits))
    else begin
      $error("More commands outstanding than credits");
      fail_cnt++;
    end

  ack_pulse: assert property (@(posedge clk_i) disable iff (!rst_ni)
    ack_o |=> !ack_o)
    else begin
      $error("Acknowledge held longer than one cycle");
      fail_cnt++;
    end

endmodule

bind addrgen_top addrgen_asserts u_asserts (.*);

// File: hw/addrgen_top.sv
//////////////////////////////////////////////////
// Vector memory address generator, top level
// Turns vector load/store requests into AXI AR/AW
// requests and matching load/store unit commands
//////////////////////////////////////////////////

`timescale 1ns/10ps

module addrgen_top (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  // Sequencer request
  input  logic                   req_valid_i,
  input  vmem_pkg::vaddr_t       req_addr_i,
  input  vmem_pkg::vlen_t        req_len_i,
  input  vmem_pkg::stride_t      req_stride_i,
  input  vmem_pkg::vew_e         req_vew_i,
  input  logic                   req_is_load_i,
  input  logic                   req_unit_stride_i,
  output logic                   ack_o,
  output logic                   error_o,
  // AXI read address channel
  output logic                   ar_valid_o,
  input  logic                   ar_ready_i,
  output vmem_pkg::vaddr_t       ar_addr_o,
  output axi_cfg_pkg::axi_len_t  ar_len_o,
  output axi_cfg_pkg::axi_size_t ar_size_o,
  output axi_cfg_pkg::axi_burst_t ar_burst_o,
  // AXI write address channel
  output logic                   aw_valid_o,
  input  logic                   aw_ready_i,
  output vmem_pkg::vaddr_t       aw_addr_o,
  output axi_cfg_pkg::axi_len_t  aw_len_o,
  output axi_cfg_pkg::axi_size_t aw_size_o,
  output axi_cfg_pkg::axi_burst_t aw_burst_o,
  // Load/store unit commands
  output logic                   cmd_valid_o,
  output vmem_pkg::vaddr_t       cmd_addr_o,
  output axi_cfg_pkg::axi_len_t  cmd_len_o,
  output axi_cfg_pkg::axi_size_t cmd_size_o,
  output logic                   cmd_is_load_o,
  input  logic                   credit_i
);

  import vmem_pkg::*;
  import axi_cfg_pkg::*;

  // Job from the front end
  logic      job_valid;
  vaddr_t    job_addr;
  vlen_t     job_len;
  stride_t   job_stride;
  vew_e      job_vew;
  logic      job_is_load;
  logic      job_unit_stride;
  logic      job_done;

  // Burst boundary lookup
  vaddr_t    cur_addr;
  vaddr_t    rem_bytes;
  vaddr_t    burst_end_addr;
  axi_len_t  burst_beats;

  // Credit handshake
  logic      push;
  logic      push_is_load;
  logic      may_push;

  mem_op_frontend u_frontend (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .req_valid_i       (req_valid_i),
    .req_addr_i        (req_addr_i),
    .req_len_i         (req_len_i),
    .req_stride_i      (req_stride_i),
    .req_vew_i         (req_vew_i),
    .req_is_load_i     (req_is_load_i),
    .req_unit_stride_i (req_unit_stride_i),
    .ack_o             (ack_o),
    .error_o           (error_o),
    .job_valid_o       (job_valid),
    .job_addr_o        (job_addr),
    .job_len_o         (job_len),
    .job_stride_o      (job_stride),
    .job_vew_o         (job_vew),
    .job_is_load_o     (job_is_load),
    .job_unit_stride_o (job_unit_stride),
    .job_done_i        (job_done)
  );

  axi_req_gen u_req_gen (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .job_valid_i       (job_valid),
    .job_addr_i        (job_addr),
    .job_len_i         (job_len),
    .job_stride_i      (job_stride),
    .job_vew_i         (job_vew),
    .job_is_load_i     (job_is_load),
    .job_unit_stride_i (job_unit_stride),
    .job_done_o        (job_done),
    .ar_valid_o        (ar_valid_o),
    .ar_ready_i        (ar_ready_i),
    .ar_addr_o         (ar_addr_o),
    .ar_len_o          (ar_len_o),
    .ar_size_o         (ar_size_o),
    .ar_burst_o        (ar_burst_o),
    .aw_valid_o        (aw_valid_o),
    .aw_ready_i        (aw_ready_i),
    .aw_addr_o         (aw_addr_o),
    .aw_len_o          (aw_len_o),
    .aw_size_o         (aw_size_o),
    .aw_burst_o        (aw_burst_o),
    .cmd_valid_o       (cmd_valid_o),
    .cmd_addr_o        (cmd_addr_o),
    .cmd_len_o         (cmd_len_o),
    .cmd_size_o        (cmd_size_o),
    .cmd_is_load_o     (cmd_is_load_o),
    .cur_addr_o        (cur_addr),
    .rem_bytes_o       (rem_bytes),
    .end_addr_i        (burst_end_addr),
    .beats_i           (burst_beats),
    .push_o            (push),
    .push_is_load_o    (push_is_load),
    .may_push_i        (may_push)
  );

  burst_boundary u_boundary (
    .cur_addr_i  (cur_addr),
    .rem_bytes_i (rem_bytes),
    .end_addr_o  (burst_end_addr),
    .beats_o     (burst_beats)
  );

  lsu_credit_tracker u_credits (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .push_i         (push),
    .push_is_load_i (push_is_load),
    .credit_i       (credit_i),
    .may_push_o     (may_push)
  );

endmodule

// File: hw/axi_req_gen.sv
//////////////////////////////////////////////////
// AXI request generator
// Walks a job as INCR bursts or per-element
// requests and pushes one LSU command per transfer
//////////////////////////////////////////////////

`timescale 1ns/10ps

module axi_req_gen (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  // Job from the front end
  input  logic                    job_valid_i,
  input  vmem_pkg::vaddr_t        job_addr_i,
  input  vmem_pkg::vlen_t         job_len_i,
  input  vmem_pkg::stride_t       job_stride_i,
  input  vmem_pkg::vew_e          job_vew_i,
  input  logic                    job_is_load_i,
  input  logic                    job_unit_stride_i,
  output logic                    job_done_o,
  // AXI read address channel
  output logic                    ar_valid_o,
  input  logic                    ar_ready_i,
  output vmem_pkg::vaddr_t        ar_addr_o,
  output axi_cfg_pkg::axi_len_t   ar_len_o,
  output axi_cfg_pkg::axi_size_t  ar_size_o,
  output axi_cfg_pkg::axi_burst_t ar_burst_o,
  // AXI write address channel
  output logic                    aw_valid_o,
  input  logic                    aw_ready_i,
  output vmem_pkg::vaddr_t        aw_addr_o,
  output axi_cfg_pkg::axi_len_t   aw_len_o,
  output axi_cfg_pkg::axi_size_t  aw_size_o,
  output axi_cfg_pkg::axi_burst_t aw_burst_o,
  // LSU commands
  output logic                    cmd_valid_o,
  output vmem_pkg::vaddr_t        cmd_addr_o,
  output axi_cfg_pkg::axi_len_t   cmd_len_o,
  output axi_cfg_pkg::axi_size_t  cmd_size_o,
  output logic                    cmd_is_load_o,
  // Burst boundary lookup
  output vmem_pkg::vaddr_t        cur_addr_o,
  output vmem_pkg::vaddr_t        rem_bytes_o,
  input  vmem_pkg::vaddr_t        end_addr_i,
  input  axi_cfg_pkg::axi_len_t   beats_i,
  // Credit tracker
  output logic                    push_o,
  output logic                    push_is_load_o,
  input  logic                    may_push_i
);

  import vmem_pkg::*;
  import axi_cfg_pkg::*;

  typedef enum logic {
    IDLE,
    REQUEST
  } state_e;

  state_e    state_q;

  // Working copy of the job
  vaddr_t    addr_q;
  vlen_t     rem_q;
  stride_t   stride_q;
  vew_e      vew_q;
  logic      is_load_q;
  logic      unit_q;

  axi_len_t  ax_len;
  axi_size_t ax_size;
  logic      ax_valid;
  logic      ax_ready;
  logic      fire;
  logic      last;
  vaddr_t    covered;
  vaddr_t    next_addr;
  vlen_t     next_rem;

  assign cur_addr_o  = addr_q;
  assign rem_bytes_o = vaddr_t'(rem_q) << vew_q;

  //////////////////////////////////////////////////
  // Request shape and next position
  //////////////////////////////////////////////////

  always_comb begin
    covered = '0;
    if (unit_q) begin
      ax_len    = beats_i;
      ax_size   = axi_size_t'(AxiSizeLog);
      covered   = (end_addr_i - addr_q + vaddr_t'(1)) >> vew_q;
      last      = (covered >= vaddr_t'(rem_q));
      next_addr = end_addr_i + vaddr_t'(1);
      next_rem  = last ? '0 : rem_q - vlen_t'(covered);
    end else begin
      // Elements wider than the bus take several full-width beats
      if (int'(vew_q) > AxiSizeLog) begin
        ax_len  = axi_len_t'((1 << (int'(vew_q) - AxiSizeLog)) - 1);
        ax_size = axi_size_t'(AxiSizeLog);
      end else begin
        ax_len  = '0;
        ax_size = axi_size_t'(vew_q);
      end
      last      = (rem_q == vlen_t'(1));
      next_addr = addr_q + stride_q;
      next_rem  = rem_q - vlen_t'(1);
    end
  end

  // Only offer a request the LSUs can take
  assign ax_valid = (state_q == REQUEST) && may_push_i;
  assign ax_ready = is_load_q ? ar_ready_i : aw_ready_i;
  assign fire     = ax_valid && ax_ready;

  assign ar_valid_o = ax_valid && is_load_q;
  assign ar_addr_o  = addr_q;
  assign ar_len_o   = ax_len;
  assign ar_size_o  = ax_size;
  assign ar_burst_o = BurstIncr;

  assign aw_valid_o = ax_valid && !is_load_q;
  assign aw_addr_o  = addr_q;
  assign aw_len_o   = ax_len;
  assign aw_size_o  = ax_size;
  assign aw_burst_o = BurstIncr;

  // Command goes out together with its AXI transfer
  assign cmd_valid_o    = fire;
  assign cmd_addr_o     = addr_q;
  assign cmd_len_o      = ax_len;
  assign cmd_size_o     = ax_size;
  assign cmd_is_load_o  = is_load_q;
  assign push_o         = fire;
  assign push_is_load_o = is_load_q;

  // An empty job finishes at once
  assign job_done_o = (fire && last) ||
                      (state_q == IDLE && job_valid_i && job_len_i == '0);

  //////////////////////////////////////////////////
  // State and job registers
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= IDLE;
    end else if (state_q == IDLE) begin
      if (job_valid_i && job_len_i != '0) begin
        state_q <= REQUEST;
      end
    end else if (fire && last) begin
      state_q <= IDLE;
    end
  end

  always_ff @(posedge clk_i) begin
    if (state_q == IDLE) begin
      addr_q    <= job_addr_i;
      rem_q     <= job_len_i;
      stride_q  <= job_stride_i;
      vew_q     <= job_vew_i;
      is_load_q <= job_is_load_i;
      unit_q    <= job_unit_stride_i;
    end else if (fire) begin
      addr_q <= next_addr;
      rem_q  <= next_rem;
    end
  end

endmodule

// File: hw/mem_op_frontend.sv
//////////////////////////////////////////////////
// Request front end
// Registers a vector memory request, checks its
// alignment and issues the job or an error ack
//////////////////////////////////////////////////

`timescale 1ns/10ps

module mem_op_frontend (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              req_valid_i,
  input  vmem_pkg::vaddr_t  req_addr_i,
  input  vmem_pkg::vlen_t   req_len_i,
  input  vmem_pkg::stride_t req_stride_i,
  input  vmem_pkg::vew_e    req_vew_i,
  input  logic              req_is_load_i,
  input  logic              req_unit_stride_i,
  output logic              ack_o,
  output logic              error_o,
  output logic              job_valid_o,
  output vmem_pkg::vaddr_t  job_addr_o,
  output vmem_pkg::vlen_t   job_len_o,
  output vmem_pkg::stride_t job_stride_o,
  output vmem_pkg::vew_e    job_vew_o,
  output logic              job_is_load_o,
  output logic              job_unit_stride_o,
  input  logic              job_done_i
);

  import vmem_pkg::*;

  typedef enum logic [1:0] {
    IDLE,
    CHECK,
    BUSY,
    DONE
  } state_e;

  state_e state_q, state_d;
  logic   err_q;
  logic   misaligned;

  // Request fields, captured once in IDLE
  always_ff @(posedge clk_i) begin
    if (state_q == IDLE && req_valid_i) begin
      job_addr_o        <= req_addr_i;
      job_len_o         <= req_len_i;
      job_stride_o      <= req_stride_i;
      job_vew_o         <= req_vew_i;
      job_is_load_o     <= req_is_load_i;
      job_unit_stride_o <= req_unit_stride_i;
    end
  end

  // Any low address bit below the element size is an error
  assign misaligned = |(job_addr_o & ((vaddr_t'(1) << job_vew_o) - vaddr_t'(1)));

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: begin
        if (req_valid_i) begin
          state_d = CHECK;
        end
      end
      CHECK: begin
        state_d = misaligned ? DONE : BUSY;
      end
      BUSY: begin
        if (job_done_i) begin
          state_d = DONE;
        end
      end
      default: begin
        state_d = IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= IDLE;
      err_q   <= 1'b0;
    end else begin
      state_q <= state_d;
      if (state_q == CHECK) begin
        err_q <= misaligned;
      end
    end
  end

  assign job_valid_o = (state_q == BUSY);
  assign ack_o       = (state_q == DONE);
  assign error_o     = (state_q == DONE) && err_q;

endmodule

// File: hw/lsu_credit_tracker.sv
//////////////////////////////////////////////////
// LSU command credit tracker
// Counts free command slots and keeps the
// direction of the commands still outstanding
//////////////////////////////////////////////////

`timescale 1ns/10ps

module lsu_credit_tracker (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic push_i,
  input  logic push_is_load_i,
  input  logic credit_i,
  output logic may_push_o
);

  import vmem_pkg::*;

  localparam credit_cnt_t FullCredits = credit_cnt_t'(CmdCredits);

  credit_cnt_t cnt_q;
  logic        dir_is_load_q;
  logic        all_home;

  assign all_home = (cnt_q == FullCredits);

  // A direction switch needs every earlier command consumed
  assign may_push_o = (cnt_q != '0) && (all_home || (dir_is_load_q == push_is_load_i));

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q         <= FullCredits;
      dir_is_load_q <= 1'b0;
    end else begin
      case ({push_i, credit_i})
        2'b10:   cnt_q <= cnt_q - credit_cnt_t'(1);
        2'b01:   cnt_q <= cnt_q + credit_cnt_t'(1);
        default: cnt_q <= cnt_q;
      endcase
      if (push_i) begin
        dir_is_load_q <= push_is_load_i;
      end
    end
  end

endmodule

// File: hw/burst_boundary.sv
//////////////////////////////////////////////////
// Unit-stride burst boundary
// Finds the last byte of the next INCR burst and
// its beat count
//////////////////////////////////////////////////

`timescale 1ns/10ps

module burst_boundary (
  input  vmem_pkg::vaddr_t      cur_addr_i,
  input  vmem_pkg::vaddr_t      rem_bytes_i,
  output vmem_pkg::vaddr_t      end_addr_o,
  output axi_cfg_pkg::axi_len_t beats_o
);

  import vmem_pkg::*;
  import axi_cfg_pkg::*;

  localparam vaddr_t BusMask       = vaddr_t'(AxiDataBytes - 1);
  localparam vaddr_t MaxBurstBytes = vaddr_t'(MaxBurstBeats * AxiDataBytes);

  vaddr_t start_aligned;
  vaddr_t len_end;
  vaddr_t max_end;
  vaddr_t page_end;
  vaddr_t end_sel;

  always_comb begin
    start_aligned = cur_addr_i & ~BusMask;

    // Last byte of the beat holding the final requested byte
    len_end  = (cur_addr_i + rem_bytes_i - vaddr_t'(1)) | BusMask;
    max_end  = start_aligned + MaxBurstBytes - vaddr_t'(1);
    page_end = {cur_addr_i[$bits(vaddr_t)-1:PageOffsetBits], {PageOffsetBits{1'b1}}};

    // Smallest of the three candidate ends
    end_sel = len_end;
    if (max_end < end_sel) begin
      end_sel = max_end;
    end
    if (page_end < end_sel) begin
      end_sel = page_end;
    end
  end

  assign end_addr_o = end_sel;
  // end_sel is the last byte of a beat, so this is already beats minus one
  assign beats_o    = axi_len_t'((end_sel - start_aligned) >> AxiSizeLog);

endmodule

// File: hw/axi_cfg_pkg.sv
//////////////////////////////////////////////////
// AXI bus geometry
// Data width, page size, burst limits and the
// field types of the address channels
//////////////////////////////////////////////////

package axi_cfg_pkg;

  //////////////////////////////////////////////////
  // Bus geometry
  //////////////////////////////////////////////////

  // Data bus width in bytes
  localparam int unsigned AxiDataBytes = 4;

  // log2 of the bus width, used as the full-width AxSIZE
  localparam int unsigned AxiSizeLog = 2;

  // A burst may not cross a 4 KiB page
  localparam int unsigned PageOffsetBits = 12;

  // Longest INCR burst allowed by AXI4
  localparam int unsigned MaxBurstBeats = 256;

  //////////////////////////////////////////////////
  // Address channel fields
  //////////////////////////////////////////////////

  // AxLEN, beats minus one
  typedef logic [7:0] axi_len_t;

  // AxSIZE, log2 of bytes per beat
  typedef logic [2:0] axi_size_t;

  // AxBURST
  typedef logic [1:0] axi_burst_t;

  localparam axi_burst_t BurstIncr = 2'b01;

endpackage

// File: hw/vmem_pkg.sv
//////////////////////////////////////////////////
// Vector memory request definitions
// Address, length, stride and element width types
// plus the command credit budget of the LSUs
//////////////////////////////////////////////////

package vmem_pkg;

  //////////////////////////////////////////////////
  // Request fields
  //////////////////////////////////////////////////

  // Byte address of the first element
  typedef logic [31:0] vaddr_t;

  // Number of elements in one vector access
  typedef logic [15:0] vlen_t;

  // Byte distance between two strided elements
  typedef logic [31:0] stride_t;

  // Element width, encoded as log2 of the byte count
  typedef enum logic [1:0] {
    EW8  = 2'd0,
    EW16 = 2'd1,
    EW32 = 2'd2,
    EW64 = 2'd3
  } vew_e;

  //////////////////////////////////////////////////
  // Command credits
  //////////////////////////////////////////////////

  // Command slots available in the load/store units
  localparam int unsigned CmdCredits = 4;

  // Wide enough to hold the full credit count
  typedef logic [2:0] credit_cnt_t;

endpackage
